// File: core_defs.svh
// Core size definitions
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_DATA_WIDTH 32
`define CORE_REG_PER_CHANNEL 16
`define CORE_MAX_CHANNELS 4
`define CORE_ISTORE_DEPTH 256
`define CORE_HOST_ADDR_WIDTH 10

// Channel select and full register address
`define CORE_CH_WIDTH ($clog2(`CORE_MAX_CHANNELS))
`define CORE_REG_ADDR_WIDTH (`CORE_CH_WIDTH + $clog2(`CORE_REG_PER_CHANNEL))

`endif

// File: core_isa_pkg.sv
// Instruction set types
`include "core_defs.svh"

package core_isa_pkg;

    // Codes above op_stop are illegal
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_and  = 5'd3,
        op_or   = 5'd4,
        op_xor  = 5'd5,
        op_ldi  = 5'd6,
        op_mov  = 5'd7,
        op_stop = 5'd8
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  dest;
        logic [3:0]  src_a;
        logic [3:0]  src_b;
        logic [14:0] imm;
    } instr_t;

    // One channel of one instruction
    typedef struct packed {
        instr_t                    instr;
        logic [`CORE_CH_WIDTH-1:0] channel;
        logic                      last;
    } issue_t;

    typedef struct packed {
        opcode_t                         opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_DATA_WIDTH-1:0]     imm;
        logic                            last;
    } exec_op_t;

endpackage

// File: core_bus_pkg.sv
// Register file bus types
`include "core_defs.svh"

package core_bus_pkg;

    // Last marks the final channel of an instruction
    typedef struct packed {
        logic [`CORE_REG_ADDR_WIDTH-1:0] addr;
        logic [`CORE_DATA_WIDTH-1:0]     data;
        logic                            last;
    } reg_write_t;

    typedef struct packed {
        logic [`CORE_REG_ADDR_WIDTH-1:0] addr;
        logic [`CORE_DATA_WIDTH-1:0]     data;
    } host_req_t;

endpackage

// File: core_control_unit.sv
// Core control unit
`timescale 1ns/100ps
`include "core_defs.svh"

module core_control_unit (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    run,
    input  logic [`CORE_CH_WIDTH:0]                 n_channels,
    input  logic                                    store_write,
    input  logic [$clog2(`CORE_ISTORE_DEPTH)-1:0]   store_addr,
    input  core_isa_pkg::instr_t                    store_data,
    input  logic                                    alu_write_valid,
    input  core_bus_pkg::reg_write_t                alu_write,
    output core_isa_pkg::issue_t                    issue,
    output logic                                    issue_valid,
    output logic                                    done,
    output logic                                    fault
);

    localparam int pc_width = $clog2(`CORE_ISTORE_DEPTH);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_issue,
        st_wait
    } state_t;

    state_t state;
    core_isa_pkg::instr_t istore [`CORE_ISTORE_DEPTH];
    core_isa_pkg::instr_t cur_instr;
    logic [pc_width-1:0] pc;
    logic [`CORE_CH_WIDTH-1:0] ch_cnt;
    logic legal;
    logic is_stop;
    logic last_ch;

    ////////////////////////////////////////
    // Instruction store
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (store_write) begin
            istore[store_addr] <= store_data;
        end
        if (state == st_fetch) begin
            cur_instr <= istore[pc];
        end
    end

    always_comb begin
        case (cur_instr.opcode)
            core_isa_pkg::op_nop, core_isa_pkg::op_add, core_isa_pkg::op_sub,
            core_isa_pkg::op_and, core_isa_pkg::op_or, core_isa_pkg::op_xor,
            core_isa_pkg::op_ldi, core_isa_pkg::op_mov, core_isa_pkg::op_stop:
                legal = 1'b1;
            default:
                legal = 1'b0;
        endcase
    end

    assign is_stop = cur_instr.opcode == core_isa_pkg::op_stop;
    assign last_ch = {1'b0, ch_cnt} == n_channels - 1'b1;

    assign issue_valid = state == st_issue && legal && !is_stop;
    assign issue = '{instr: cur_instr, channel: ch_cnt, last: last_ch};

    ////////////////////////////////////////
    // Sequencing FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_idle;
            pc <= '0;
            ch_cnt <= '0;
            done <= 1'b0;
            fault <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        fault <= 1'b0;
                        pc <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    ch_cnt <= '0;
                    state <= st_issue;
                end
                st_issue: begin
                    if (!legal || is_stop) begin
                        // Stop and fault both end the run here
                        fault <= !legal;
                        done <= 1'b1;
                        state <= st_idle;
                    end else if (last_ch) begin
                        state <= st_wait;
                    end else begin
                        ch_cnt <= ch_cnt + 1'b1;
                    end
                end
                default: begin
                    if (alu_write_valid && alu_write.last) begin
                        pc <= pc + 1'b1;
                        state <= st_fetch;
                    end
                end
            endcase
        end
    end

    // Nothing issues while the last channel is still on its way to writeback
    assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |-> !$past(issue_valid && issue.last) &&
                        !$past(issue_valid && issue.last, 2));

    // The last writeback only ever closes an instruction in flight
    assert property (@(posedge clock) disable iff (!rst_n)
        alu_write_valid && alu_write.last |-> state == st_wait);

endmodule

// File: core_decoder.sv
// Instruction decoder
`timescale 1ns/100ps
`include "core_defs.svh"

module core_decoder (
    input  logic                              clock,
    input  logic                              rst_n,
    input  core_isa_pkg::issue_t              issue,
    input  logic                              issue_valid,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]   read_addr_a,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]   read_addr_b,
    output core_isa_pkg::exec_op_t            exec_op,
    output logic                              exec_valid
);

    localparam int imm_width = $bits(issue.instr.imm);

    core_isa_pkg::instr_t instr;
    logic [$clog2(`CORE_REG_PER_CHANNEL)-1:0] sel_a;

    assign instr = issue.instr;

    // A nop reads its own destination so that the write back leaves it unchanged
    assign sel_a = instr.opcode == core_isa_pkg::op_nop ? instr.dest : instr.src_a;

    assign read_addr_a = {issue.channel, sel_a};
    assign read_addr_b = {issue.channel, instr.src_b};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= issue_valid;
        end
    end

    // Lines up with the register file read latency
    always_ff @(posedge clock) begin
        exec_op.opcode <= instr.opcode;
        exec_op.dest <= {issue.channel, instr.dest};
        exec_op.imm <= {{(`CORE_DATA_WIDTH - imm_width){instr.imm[imm_width-1]}}, instr.imm};
        exec_op.last <= issue.last;
    end

endmodule

// File: core_alu.sv
// Integer execute stage
`timescale 1ns/100ps
`include "core_defs.svh"

module core_alu (
    input  logic                            clock,
    input  logic                            rst_n,
    input  core_isa_pkg::exec_op_t          exec_op,
    input  logic                            exec_valid,
    input  logic [`CORE_DATA_WIDTH-1:0]     operand_a,
    input  logic [`CORE_DATA_WIDTH-1:0]     operand_b,
    output core_bus_pkg::reg_write_t        alu_write,
    output logic                            alu_write_valid
);

    logic [`CORE_DATA_WIDTH-1:0] result;
    logic strobe;

    always_comb begin
        case (exec_op.opcode)
            core_isa_pkg::op_add: result = operand_a + operand_b;
            core_isa_pkg::op_sub: result = operand_a - operand_b;
            core_isa_pkg::op_and: result = operand_a & operand_b;
            core_isa_pkg::op_or:  result = operand_a | operand_b;
            core_isa_pkg::op_xor: result = operand_a ^ operand_b;
            core_isa_pkg::op_ldi: result = exec_op.imm;
            // Nop rewrites the destination with its own value
            core_isa_pkg::op_mov, core_isa_pkg::op_nop: result = operand_a;
            default: result = '0;
        endcase
    end

    // Nop only strobes for its last channel to close the wait
    assign strobe = exec_valid && (exec_op.opcode != core_isa_pkg::op_nop || exec_op.last);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_write_valid <= 1'b0;
        end else begin
            alu_write_valid <= strobe;
        end
    end

    always_ff @(posedge clock) begin
        alu_write <= '{addr: exec_op.dest, data: result, last: exec_op.last};
    end

endmodule

// File: core_write_arbiter.sv
// Register file write arbiter
`timescale 1ns/100ps

module core_write_arbiter (
    input  logic                        clock,
    input  logic                        rst_n,
    input  core_bus_pkg::reg_write_t    alu_write,
    input  logic                        alu_write_valid,
    input  core_bus_pkg::host_req_t     host_req,
    input  logic                        host_req_valid,
    output core_bus_pkg::reg_write_t    rf_write,
    output logic                        rf_write_valid,
    output logic                        host_busy
);

    core_bus_pkg::host_req_t held;
    logic held_valid;

    // ALU first, then the held host write, then a fresh one
    always_comb begin
        if (alu_write_valid) begin
            rf_write = alu_write;
        end else if (held_valid) begin
            rf_write = '{addr: held.addr, data: held.data, last: 1'b0};
        end else begin
            rf_write = '{addr: host_req.addr, data: host_req.data, last: 1'b0};
        end
    end

    assign rf_write_valid = alu_write_valid || held_valid || host_req_valid;
    assign host_busy = held_valid;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (alu_write_valid && host_req_valid) begin
            held_valid <= 1'b1;
        end else if (!alu_write_valid) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_write_valid && host_req_valid) begin
            held <= host_req;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        host_req_valid |-> !host_busy);

endmodule

// File: core_register_file.sv
// Banked register file
`timescale 1ns/100ps
`include "core_defs.svh"

module core_register_file (
    input  logic                              clock,
    input  logic                              rst_n,
    input  core_bus_pkg::reg_write_t          rf_write,
    input  logic                              rf_write_valid,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0]   read_addr_a,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0]   read_addr_b,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0]   host_read_addr,
    output logic [`CORE_DATA_WIDTH-1:0]       operand_a,
    output logic [`CORE_DATA_WIDTH-1:0]       operand_b,
    output logic [`CORE_DATA_WIDTH-1:0]       host_read_data
);

    localparam int rf_words = `CORE_MAX_CHANNELS * `CORE_REG_PER_CHANNEL;

    // Channel number sits in the top address bits
    logic [`CORE_DATA_WIDTH-1:0] mem [rf_words];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < rf_words; i++) begin
                mem[i] <= '0;
            end
        end else if (rf_write_valid) begin
            mem[rf_write.addr] <= rf_write.data;
        end
    end

    // All read ports have one cycle of latency
    always_ff @(posedge clock) begin
        operand_a <= mem[read_addr_a];
        operand_b <= mem[read_addr_b];
        host_read_data <= mem[host_read_addr];
    end

endmodule

// File: core_host_endpoint.sv
// Host endpoint
`timescale 1ns/100ps
`include "core_defs.svh"

module core_host_endpoint (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    host_write,
    input  logic                                    host_read,
    input  logic [`CORE_HOST_ADDR_WIDTH-1:0]        host_addr,
    input  logic [`CORE_DATA_WIDTH-1:0]             host_wdata,
    input  logic                                    host_busy,
    output logic                                    store_write,
    output logic [$clog2(`CORE_ISTORE_DEPTH)-1:0]   store_addr,
    output core_isa_pkg::instr_t                    store_data,
    output core_bus_pkg::host_req_t                 host_req,
    output logic                                    host_req_valid,
    output logic [`CORE_REG_ADDR_WIDTH-1:0]         host_read_addr,
    input  logic [`CORE_DATA_WIDTH-1:0]             host_read_data,
    output logic [`CORE_DATA_WIDTH-1:0]             host_rdata,
    output logic                                    host_rvalid,
    output logic [`CORE_CH_WIDTH:0]                 n_channels
);

    localparam int reg_base = 'h100;
    localparam int rf_words = `CORE_MAX_CHANNELS * `CORE_REG_PER_CHANNEL;
    localparam int count_addr = 'h200;

    logic store_region;
    logic reg_region;
    logic count_ok;
    logic read_pend;
    logic read_hit;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign store_region = host_addr < `CORE_ISTORE_DEPTH;
    assign reg_region = host_addr >= reg_base && host_addr < reg_base + rf_words;

    // Only counts from one up to the maximum are taken
    assign count_ok = host_addr == count_addr && host_wdata != '0 &&
                      host_wdata <= `CORE_MAX_CHANNELS;

    assign store_write = host_write && store_region;
    assign store_addr = host_addr[$clog2(`CORE_ISTORE_DEPTH)-1:0];
    assign store_data = core_isa_pkg::instr_t'(host_wdata);

    assign host_req = '{addr: host_addr[`CORE_REG_ADDR_WIDTH-1:0], data: host_wdata};
    assign host_req_valid = host_write && reg_region && !host_busy;
    assign host_read_addr = host_addr[`CORE_REG_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            n_channels <= 1;
        end else if (host_write && count_ok) begin
            n_channels <= host_wdata[`CORE_CH_WIDTH:0];
        end
    end

    ////////////////////////////////////////
    // Read sequencing
    ////////////////////////////////////////

    // Register file data is ready one cycle after the strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_pend <= 1'b0;
            read_hit <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            read_pend <= host_read;
            read_hit <= host_read && reg_region;
            host_rvalid <= read_pend;
        end
    end

    // Unmapped reads answer with zero
    always_ff @(posedge clock) begin
        host_rdata <= read_hit ? host_read_data : '0;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        n_channels >= 1 && n_channels <= `CORE_MAX_CHANNELS);

endmodule

// File: core_top.sv
// Processing core top level
`timescale 1ns/100ps
`include "core_defs.svh"

module core_top (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic                                host_write,
    input  logic                                host_read,
    input  logic [`CORE_HOST_ADDR_WIDTH-1:0]    host_addr,
    input  logic [`CORE_DATA_WIDTH-1:0]         host_wdata,
    output logic [`CORE_DATA_WIDTH-1:0]         host_rdata,
    output logic                                host_rvalid,
    output logic                                host_busy,
    output logic                                done,
    output logic                                fault
);

    logic [`CORE_CH_WIDTH:0] n_channels;
    logic store_write;
    logic [$clog2(`CORE_ISTORE_DEPTH)-1:0] store_addr;
    core_isa_pkg::instr_t store_data;

    // Issue path
    core_isa_pkg::issue_t issue;
    logic issue_valid;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_a;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_b;
    core_isa_pkg::exec_op_t exec_op;
    logic exec_valid;
    logic [`CORE_DATA_WIDTH-1:0] operand_a;
    logic [`CORE_DATA_WIDTH-1:0] operand_b;

    // Write port and host access
    core_bus_pkg::reg_write_t alu_write;
    logic alu_write_valid;
    core_bus_pkg::host_req_t host_req;
    logic host_req_valid;
    core_bus_pkg::reg_write_t rf_write;
    logic rf_write_valid;
    logic [`CORE_REG_ADDR_WIDTH-1:0] host_read_addr;
    logic [`CORE_DATA_WIDTH-1:0] host_read_data;

    core_control_unit u_control_unit (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .n_channels(n_channels),
        .store_write(store_write),
        .store_addr(store_addr),
        .store_data(store_data),
        .alu_write_valid(alu_write_valid),
        .alu_write(alu_write),
        .issue(issue),
        .issue_valid(issue_valid),
        .done(done),
        .fault(fault)
    );

    core_decoder u_decoder (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue),
        .issue_valid(issue_valid),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .exec_op(exec_op),
        .exec_valid(exec_valid)
    );

    core_alu u_alu (
        .clock(clock),
        .rst_n(rst_n),
        .exec_op(exec_op),
        .exec_valid(exec_valid),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .alu_write(alu_write),
        .alu_write_valid(alu_write_valid)
    );

    core_write_arbiter u_write_arbiter (
        .clock(clock),
        .rst_n(rst_n),
        .alu_write(alu_write),
        .alu_write_valid(alu_write_valid),
        .host_req(host_req),
        .host_req_valid(host_req_valid),
        .rf_write(rf_write),
        .rf_write_valid(rf_write_valid),
        .host_busy(host_busy)
    );

    core_register_file u_register_file (
        .clock(clock),
        .rst_n(rst_n),
        .rf_write(rf_write),
        .rf_write_valid(rf_write_valid),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .host_read_addr(host_read_addr),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .host_read_data(host_read_data)
    );

    core_host_endpoint u_host_endpoint (
        .clock(clock),
        .rst_n(rst_n),
        .host_write(host_write),
        .host_read(host_read),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_busy(host_busy),
        .store_write(store_write),
        .store_addr(store_addr),
        .store_data(store_data),
        .host_req(host_req),
        .host_req_valid(host_req_valid),
        .host_read_addr(host_read_addr),
        .host_read_data(host_read_data),
        .host_rdata(host_rdata),
        .host_rvalid(host_rvalid),
        .n_channels(n_channels)
    );

endmodule

// File: tb_core.sv
// Core testbench
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_core;

    localparam int clk_period = 4;
    localparam int rf_words = `CORE_MAX_CHANNELS * `CORE_REG_PER_CHANNEL;
    localparam int prog_len = 24;
    localparam int prog_regs = 12;
    localparam int num_programs = 7;
    localparam int watchdog_cycles = 20 * num_programs * prog_len * `CORE_MAX_CHANNELS * 8;
    localparam int done_timeout = prog_len * `CORE_MAX_CHANNELS * 8;
    localparam int busy_timeout = 64;
    localparam int read_timeout = 16;
    localparam logic [`CORE_HOST_ADDR_WIDTH-1:0] reg_base = 'h100;
    localparam logic [`CORE_HOST_ADDR_WIDTH-1:0] count_addr = 'h200;

    logic clock;
    logic rst_n;
    logic run;
    logic host_write;
    logic host_read;
    logic [`CORE_HOST_ADDR_WIDTH-1:0] host_addr;
    logic [`CORE_DATA_WIDTH-1:0] host_wdata;
    logic [`CORE_DATA_WIDTH-1:0] host_rdata;
    logic host_rvalid;
    logic host_busy;
    logic done;
    logic fault;

    integer seed = 32'h119f_ccbe;
    logic [`CORE_DATA_WIDTH-1:0] model [rf_words];
    core_isa_pkg::instr_t prog [$];
    logic [`CORE_DATA_WIDTH-1:0] exp_data [$];
    int exp_index [$];

    core_top u_dut (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .host_write(host_write),
        .host_read(host_read),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .host_rvalid(host_rvalid),
        .host_busy(host_busy),
        .done(done),
        .fault(fault)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Executes the program on the model array for channels below n_ch
    function automatic void run_reference(input int n_ch);
        core_isa_pkg::instr_t ins;
        logic [`CORE_DATA_WIDTH-1:0] a;
        logic [`CORE_DATA_WIDTH-1:0] b;
        logic [`CORE_DATA_WIDTH-1:0] res;
        int base;
        foreach (prog[pc]) begin
            ins = prog[pc];
            // Stop and every code above it end the program
            if (ins.opcode >= 5'd8) begin
                return;
            end
            for (int ch = 0; ch < n_ch; ch++) begin
                base = ch * `CORE_REG_PER_CHANNEL;
                a = model[base + ins.src_a];
                b = model[base + ins.src_b];
                case (ins.opcode)
                    core_isa_pkg::op_add: res = a + b;
                    core_isa_pkg::op_sub: res = a - b;
                    core_isa_pkg::op_and: res = a & b;
                    core_isa_pkg::op_or:  res = a | b;
                    core_isa_pkg::op_xor: res = a ^ b;
                    core_isa_pkg::op_ldi: res = {{(`CORE_DATA_WIDTH - 15){ins.imm[14]}}, ins.imm};
                    core_isa_pkg::op_mov: res = a;
                    default: res = model[base + ins.dest];
                endcase
                model[base + ins.dest] = res;
            end
        end
    endfunction

    // Random program over the low registers, optional illegal code at fault_at
    task automatic make_program(input int fault_at);
        logic [4:0] code;
        logic [3:0] dest;
        logic [3:0] src_a;
        logic [3:0] src_b;
        logic [14:0] imm;
        prog.delete();
        for (int i = 0; i < prog_len; i++) begin
            code = 5'(1 + $unsigned($random(seed)) % 7);
            if (i == fault_at) begin
                code = 5'(9 + $unsigned($random(seed)) % 23);
            end
            dest = 4'($unsigned($random(seed)) % prog_regs);
            src_a = 4'($unsigned($random(seed)) % prog_regs);
            src_b = 4'($unsigned($random(seed)) % prog_regs);
            imm = 15'($random(seed));
            prog.push_back(core_isa_pkg::instr_t'({code, dest, src_a, src_b, imm}));
        end
        prog.push_back(core_isa_pkg::instr_t'({5'd8, 27'd0}));
    endtask

    ////////////////////////////////////////
    // Host access
    ////////////////////////////////////////

    task automatic host_write_word(input logic [`CORE_HOST_ADDR_WIDTH-1:0] addr,
                                   input logic [`CORE_DATA_WIDTH-1:0] data);
        int waited;
        waited = 0;
        @(posedge clock);
        #0.5;
        while (host_busy === 1'b1) begin
            if (waited >= busy_timeout) begin
                fail_now("Timeout: host_busy stayed high and blocked a host write");
            end else begin
                waited++;
                @(posedge clock);
                #0.5;
            end
        end
        host_write = 1'b1;
        host_addr = addr;
        host_wdata = data;
        @(posedge clock);
        #0.5;
        host_write = 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            host_write_word(10'(i), 32'(prog[i]));
        end
    endtask

    task automatic set_channels(input int n_ch);
        host_write_word(count_addr, 32'(n_ch));
    endtask

    task automatic preload_registers();
        logic [`CORE_DATA_WIDTH-1:0] val;
        for (int idx = 0; idx < rf_words; idx++) begin
            val = $random(seed);
            model[idx] = val;
            host_write_word(reg_base + 10'(idx), val);
        end
    endtask

    // Registers at and above prog_regs are never touched by a program
    task automatic write_spare_registers(input int count);
        int idx;
        logic [`CORE_DATA_WIDTH-1:0] val;
        for (int n = 0; n < count; n++) begin
            idx = int'($unsigned($random(seed)) % `CORE_MAX_CHANNELS) * `CORE_REG_PER_CHANNEL;
            idx = idx + prog_regs + int'($unsigned($random(seed)) % 4);
            val = $random(seed);
            model[idx] = val;
            host_write_word(reg_base + 10'(idx), val);
        end
    endtask

    task automatic run_program(input logic expect_fault);
        int waited;
        waited = 0;
        @(posedge clock);
        #0.5;
        run = 1'b1;
        @(posedge clock);
        #0.5;
        run = 1'b0;
        while (done !== 1'b1) begin
            if (waited >= done_timeout) begin
                fail_now("Timeout: the run never pulsed done");
            end else begin
                waited++;
                @(posedge clock);
                #0.5;
            end
        end
        assert (fault === expect_fault)
        else fail_now($sformatf("Fail at %0t: fault is %b at done, expected %b",
                                $time, fault, expect_fault));
    endtask

    // Reads every register and leaves the checking to the compare process
    task automatic check_registers();
        int waited;
        for (int idx = 0; idx < rf_words; idx++) begin
            @(posedge clock);
            #0.5;
            host_read = 1'b1;
            host_addr = reg_base + 10'(idx);
            exp_index.push_back(idx);
            exp_data.push_back(model[idx]);
            @(posedge clock);
            #0.5;
            host_read = 1'b0;
        end
        waited = 0;
        while (exp_data.size() != 0) begin
            if (waited >= read_timeout) begin
                fail_now("Timeout: host reads did not all return host_rvalid");
            end else begin
                waited++;
                @(posedge clock);
            end
        end
    endtask

    task automatic check_idle_flags();
        assert (done === 1'b0 && fault === 1'b0 && host_busy === 1'b0 && host_rvalid === 1'b0)
        else fail_now($sformatf("Fail at %0t: after reset done=%b fault=%b busy=%b rvalid=%b",
                                $time, done, fault, host_busy, host_rvalid));
    endtask

    ////////////////////////////////////////
    // Read-back comparison
    ////////////////////////////////////////

    // Mid-cycle sampling stays clear of the DUT's edge updates
    always @(negedge clock) begin : compare_reads
        int idx;
        logic [`CORE_DATA_WIDTH-1:0] want;
        if (rst_n === 1'b1 && host_rvalid === 1'b1) begin
            if (exp_data.size() == 0) begin
                fail_now("A read response arrived with no read outstanding");
            end else begin
                idx = exp_index.pop_front();
                want = exp_data.pop_front();
                assert (host_rdata === want)
                else fail_now($sformatf("Fail at %0t: register %0d read %h, expected %h",
                                        $time, idx, host_rdata, want));
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        fail_now("Timeout: the tests did not finish within the watchdog limit");
    end

    initial begin
        rst_n = 1'b0;
        run = 1'b0;
        host_write = 1'b0;
        host_read = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (16) @(posedge clock);
        #0.5;
        rst_n = 1'b1;
        @(posedge clock);
        #0.5;
        check_idle_flags();
        check_registers();

        // All four channels
        set_channels(4);
        preload_registers();
        make_program(-1);
        load_program();
        run_program(1'b0);
        run_reference(4);
        check_registers();

        // Two channels, upper banks keep their values
        set_channels(2);
        preload_registers();
        make_program(-1);
        load_program();
        run_program(1'b0);
        run_reference(2);
        check_registers();

        // Host writes racing the ALU for the write port
        set_channels(4);
        preload_registers();
        make_program(-1);
        load_program();
        fork
            run_program(1'b0);
            write_spare_registers(60);
        join
        run_reference(4);
        check_registers();

        // Illegal opcode in the middle
        make_program(8);
        load_program();
        run_program(1'b1);
        run_reference(4);
        check_registers();

        // Back-to-back programs, the first one also clears fault
        for (int n = 0; n < 3; n++) begin
            make_program(-1);
            load_program();
            run_program(1'b0);
            run_reference(4);
            check_registers();
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
core_isa_pkg.sv
core_bus_pkg.sv
core_control_unit.sv
core_decoder.sv
core_alu.sv
core_write_arbiter.sv
core_register_file.sv
core_host_endpoint.sv
core_top.sv
tb_core.sv

// File: Bender.yml
package:
  name: core

export_include_dirs:
  - .

sources:
  - files:
      - core_isa_pkg.sv
      - core_bus_pkg.sv
      - core_control_unit.sv
      - core_decoder.sv
      - core_alu.sv
      - core_write_arbiter.sv
      - core_register_file.sv
      - core_host_endpoint.sv
      - core_top.sv
  - target: test
    files:
      - tb_core.sv
